// File: all.f
game_pkg.sv
vga_timing.sv
draw_background.sv
draw_rect.sv
hero_ctl.sv
game_ctl.sv
game_top.sv
tb_game_top.sv

// File: draw_background.sv
`timescale 1ns/1ps

module draw_background #(
    parameter int H_ACTIVE = 1024,
    parameter int V_ACTIVE = 768
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::vga_t   vga_in,
    output game_pkg::pixel_t pix
);

    localparam game_pkg::coord_t H_EDGE = game_pkg::coord_t'(H_ACTIVE - 1);
    localparam game_pkg::coord_t V_EDGE = game_pkg::coord_t'(V_ACTIVE - 1);

    logic           on_border;
    game_pkg::rgb_t rgb_nxt;

    // one pixel ring around the visible area
    assign on_border = (vga_in.hcount == '0) || (vga_in.hcount == H_EDGE) ||
                       (vga_in.vcount == '0) || (vga_in.vcount == V_EDGE);

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;
        end else if (on_border) begin
            rgb_nxt = game_pkg::COLOR_BORDER;
        end else begin
            rgb_nxt = game_pkg::COLOR_FILL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.vga <= vga_in;
            pix.rgb <= rgb_nxt;
        end
    end

endmodule

// File: draw_rect.sv
`timescale 1ns/1ps

module draw_rect #(
    parameter game_pkg::rgb_t COLOR = 12'hFFF
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::pixel_t pix_in,
    input  game_pkg::pos_t   pos,
    output game_pkg::pixel_t pix
);

    logic in_x;
    logic in_y;
    logic hit;

    //////////////////////////////
    // square membership
    //////////////////////////////

    assign in_x = (pix_in.vga.hcount >= pos.x) &&
                  (pix_in.vga.hcount < pos.x + game_pkg::OBJ_SIZE);
    assign in_y = (pix_in.vga.vcount >= pos.y) &&
                  (pix_in.vga.vcount < pos.y + game_pkg::OBJ_SIZE);

    // never paint over blanking
    assign hit = in_x && in_y && !pix_in.vga.hblnk && !pix_in.vga.vblnk;

    //////////////////////////////
    // output stage
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.vga <= pix_in.vga;
            if (hit) begin
                pix.rgb <= COLOR;
            end else begin
                pix.rgb <= pix_in.rgb;
            end
        end
    end

endmodule

// File: game_ctl.sv
`timescale 1ns/1ps

module game_ctl #(
    parameter int GOAL_X       = 482,
    parameter int GOAL_Y       = 108,
    parameter int LEVEL_FRAMES = 3600
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_start,
    input  game_pkg::pos_t   hero_pos,
    output logic             restart,
    output game_pkg::level_t level,
    output game_pkg::time_t  time_left
);

    localparam game_pkg::time_t BUDGET = game_pkg::time_t'(LEVEL_FRAMES);

    logic overlap_x;
    logic overlap_y;
    logic goal_hit;

    //////////////////////////////
    // goal detection
    //////////////////////////////

    // ranges intersect on both axes
    assign overlap_x = (hero_pos.x < GOAL_X + game_pkg::OBJ_SIZE) &&
                       (hero_pos.x + game_pkg::OBJ_SIZE > GOAL_X);
    assign overlap_y = (hero_pos.y < GOAL_Y + game_pkg::OBJ_SIZE) &&
                       (hero_pos.y + game_pkg::OBJ_SIZE > GOAL_Y);
    assign goal_hit  = overlap_x && overlap_y;

    //////////////////////////////
    // level and frame budget
    //////////////////////////////

    // hero_pos still holds the position drawn in the last frame here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level     <= '0;
            time_left <= BUDGET;
            restart   <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (frame_start) begin
                if (goal_hit) begin
                    level     <= level + 1'b1;
                    time_left <= BUDGET;
                    restart   <= 1'b1;
                end else if (time_left == '0) begin
                    // out of time, same level again
                    time_left <= BUDGET;
                    restart   <= 1'b1;
                end else begin
                    time_left <= time_left - 1'b1;
                end
            end
        end
    end

    restart_after_frame: assert property (
        @(posedge clk) disable iff (!rst_n) restart |-> $past(frame_start)
    ) else $error("restart without a preceding frame_start");

endmodule

// File: game_pkg.sv
package game_pkg;

    //////////////////////////////
    // basic scalar types
    //////////////////////////////

    // one pixel coordinate, horizontal or vertical
    typedef logic [10:0] coord_t;

    // level number, wraps after 15
    typedef logic [3:0] level_t;

    // frames left in the running level
    typedef logic [11:0] time_t;

    //////////////////////////////
    // bundles
    //////////////////////////////

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // top-left corner of an object
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // held direction buttons, plain levels
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } btn_t;

    // timing bundle travelling down the pixel pipeline
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
    } vga_t;

    // what one pipeline stage hands to the next
    typedef struct packed {
        vga_t vga;
        rgb_t rgb;
    } pixel_t;

    //////////////////////////////
    // game constants
    //////////////////////////////

    // side of goal and hero squares
    localparam int OBJ_SIZE = 8;

    // pixels per frame per held button
    localparam int HERO_STEP = 2;

    localparam rgb_t COLOR_BORDER = 12'h888;
    localparam rgb_t COLOR_FILL   = 12'h222;
    localparam rgb_t COLOR_GOAL   = 12'hF00;
    localparam rgb_t COLOR_HERO   = 12'h01C;

endpackage

// File: game_top.sv
`timescale 1ns/1ps

module game_top #(
    parameter int H_ACTIVE     = 1024,
    parameter int H_FP         = 24,
    parameter int H_SYNC       = 136,
    parameter int H_BP         = 160,
    parameter int V_ACTIVE     = 768,
    parameter int V_FP         = 3,
    parameter int V_SYNC       = 6,
    parameter int V_BP         = 29,
    parameter int START_X      = 16,
    parameter int START_Y      = 16,
    parameter int GOAL_X       = 482,
    parameter int GOAL_Y       = 108,
    parameter int LEVEL_FRAMES = 3600
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::btn_t   btn,
    output logic             hs,
    output logic             vs,
    output game_pkg::rgb_t   rgb,
    output game_pkg::level_t level,
    output game_pkg::time_t  time_left
);

    localparam game_pkg::pos_t GOAL_POS = '{
        x: game_pkg::coord_t'(GOAL_X),
        y: game_pkg::coord_t'(GOAL_Y)
    };

    game_pkg::vga_t   timing_vga;
    game_pkg::pixel_t bg_pix;
    game_pkg::pixel_t goal_pix;
    game_pkg::pixel_t hero_pix;
    game_pkg::pos_t   hero_pos;
    logic             frame_start;
    logic             restart;

    //////////////////////////////
    // pixel pipeline
    //////////////////////////////

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing_i (
        .clk(clk), .rst_n(rst_n), .vga(timing_vga), .frame_start(frame_start)
    );

    draw_background #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) background_i (
        .clk(clk), .rst_n(rst_n), .vga_in(timing_vga), .pix(bg_pix)
    );

    draw_rect #(.COLOR(game_pkg::COLOR_GOAL)) goal_layer (
        .clk(clk), .rst_n(rst_n), .pix_in(bg_pix), .pos(GOAL_POS), .pix(goal_pix)
    );

    draw_rect #(.COLOR(game_pkg::COLOR_HERO)) hero_layer (
        .clk(clk), .rst_n(rst_n), .pix_in(goal_pix), .pos(hero_pos), .pix(hero_pix)
    );

    //////////////////////////////
    // game logic
    //////////////////////////////

    hero_ctl #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .START_X(START_X), .START_Y(START_Y)
    ) hero_i (
        .clk(clk), .rst_n(rst_n), .btn(btn), .frame_start(frame_start),
        .restart(restart), .hero_pos(hero_pos)
    );

    game_ctl #(.GOAL_X(GOAL_X), .GOAL_Y(GOAL_Y), .LEVEL_FRAMES(LEVEL_FRAMES)) game_i (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start), .hero_pos(hero_pos),
        .restart(restart), .level(level), .time_left(time_left)
    );

    // sync and colour leave together, 3 cycles after the counters
    assign hs  = hero_pix.vga.hsync;
    assign vs  = hero_pix.vga.vsync;
    assign rgb = hero_pix.rgb;

endmodule

// File: hero_ctl.sv
`timescale 1ns/1ps

module hero_ctl #(
    parameter int H_ACTIVE = 1024,
    parameter int V_ACTIVE = 768,
    parameter int START_X  = 16,
    parameter int START_Y  = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  game_pkg::btn_t btn,
    input  logic           frame_start,
    input  logic           restart,
    output game_pkg::pos_t hero_pos
);

    // largest corner that keeps the square on screen
    localparam int X_MAX = H_ACTIVE - game_pkg::OBJ_SIZE;
    localparam int Y_MAX = V_ACTIVE - game_pkg::OBJ_SIZE;

    // one axis step, opposite buttons cancel
    function automatic game_pkg::coord_t step_axis(
        input game_pkg::coord_t cur,
        input logic             dec,
        input logic             inc,
        input int               max_val
    );
        int nxt;
        nxt = int'(cur);
        if (inc && !dec) begin
            nxt = nxt + game_pkg::HERO_STEP;
        end else if (dec && !inc) begin
            nxt = nxt - game_pkg::HERO_STEP;
        end
        if (nxt < 0) begin
            nxt = 0;
        end else if (nxt > max_val) begin
            nxt = max_val;
        end
        return game_pkg::coord_t'(nxt);
    endfunction

    // restart comes one cycle after frame_start and wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hero_pos.x <= game_pkg::coord_t'(START_X);
            hero_pos.y <= game_pkg::coord_t'(START_Y);
        end else if (restart) begin
            hero_pos.x <= game_pkg::coord_t'(START_X);
            hero_pos.y <= game_pkg::coord_t'(START_Y);
        end else if (frame_start) begin
            hero_pos.x <= step_axis(hero_pos.x, btn.left, btn.right, X_MAX);
            hero_pos.y <= step_axis(hero_pos.y, btn.up, btn.down, Y_MAX);
        end
    end

    hero_in_field: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int'(hero_pos.x) <= X_MAX) && (int'(hero_pos.y) <= Y_MAX)
    ) else $error("hero left the playfield");

endmodule

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_game_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: tb_game_top.sv
`timescale 1ns/1ps

module tb_game_top;

    localparam int H_ACTIVE     = 64;
    localparam int V_ACTIVE     = 48;
    localparam int H_SYNC       = 8;
    localparam int V_SYNC       = 2;
    localparam int V_FP         = 2;
    localparam int H_TOTAL      = 80;
    localparam int V_TOTAL      = 54;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int START_X      = 4;
    localparam int START_Y      = 4;
    localparam int GOAL_X       = 40;
    localparam int GOAL_Y       = 30;
    localparam int LEVEL_FRAMES = 20;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_TESTS      = 11;

    logic             clk;
    logic             rst_n;
    game_pkg::btn_t   btn;
    logic             hs;
    logic             vs;
    game_pkg::rgb_t   rgb;
    game_pkg::level_t level;
    game_pkg::time_t  time_left;

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // btn bits are up, down, left, right; 0 frames means a random hold of 1 to 5
    // expected columns of -1 are left to the model
    string          t_name [N_TESTS] = '{"static_frame", "move_right", "move_down",
        "opposite_pair", "timeout_wait", "goal_reach", "clamp_down", "timeout_again",
        "clamp_left", "clamp_up", "random_hold"};
    game_pkg::btn_t t_btn [N_TESTS] = '{4'b0000, 4'b0001, 4'b0100, 4'b1111, 4'b0000,
        4'b0101, 4'b0100, 4'b0000, 4'b0010, 4'b1000, 4'b0101};
    int t_frames [N_TESTS] = '{1, 3, 2, 2, 12, 16, 19, 2, 4, 4, 0};
    bit t_scan   [N_TESTS] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 1, 1};
    int t_exp_x  [N_TESTS] = '{4, 10, 10, 10, 4, 4, 4, 4, 0, 0, -1};
    int t_exp_y  [N_TESTS] = '{4, 4, 8, 8, 4, 4, 40, 4, 4, 0, -1};
    int t_exp_lv [N_TESTS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1, -1};
    int t_exp_tl [N_TESTS] = '{18, 15, 13, 11, 20, 20, 1, 20, 16, 12, -1};

    // scanner and model state
    int err_count = 0;
    int check_count = 0;
    bit vs_prev = 0;
    bit locked = 0;
    bit scan_on = 0;
    int h = 0;
    int v = 0;
    int hs_len = 0;
    int vs_len = 0;
    int mdl_x = START_X;
    int mdl_y = START_Y;
    int mdl_level = 0;
    int mdl_time = LEVEL_FRAMES;

    game_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(4), .H_SYNC(H_SYNC), .H_BP(4),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(2),
        .START_X(START_X), .START_Y(START_Y), .GOAL_X(GOAL_X), .GOAL_Y(GOAL_Y),
        .LEVEL_FRAMES(LEVEL_FRAMES)
    ) dut_i (
        .clk(clk), .rst_n(rst_n), .btn(btn), .hs(hs), .vs(vs), .rgb(rgb),
        .level(level), .time_left(time_left)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic bit in_square(int px, int py, int sx, int sy);
        return (px >= sx) && (px < sx + game_pkg::OBJ_SIZE) &&
               (py >= sy) && (py < sy + game_pkg::OBJ_SIZE);
    endfunction

    function automatic int axis_move(int cur, bit dec, bit inc, int hi);
        int nxt;
        nxt = cur;
        if (inc && !dec) begin
            nxt = cur + game_pkg::HERO_STEP;
        end else if (dec && !inc) begin
            nxt = cur - game_pkg::HERO_STEP;
        end
        if (nxt < 0) begin
            nxt = 0;
        end else if (nxt > hi) begin
            nxt = hi;
        end
        return nxt;
    endfunction

    function automatic game_pkg::rgb_t expected_colour(int px, int py);
        game_pkg::rgb_t c;
        if (px >= H_ACTIVE || py >= V_ACTIVE) begin
            c = '0;
        end else if (in_square(px, py, mdl_x, mdl_y)) begin
            c = game_pkg::COLOR_HERO;
        end else if (in_square(px, py, GOAL_X, GOAL_Y)) begin
            c = game_pkg::COLOR_GOAL;
        end else if (px == 0 || px == H_ACTIVE - 1 || py == 0 || py == V_ACTIVE - 1) begin
            c = game_pkg::COLOR_BORDER;
        end else begin
            c = game_pkg::COLOR_FILL;
        end
        return c;
    endfunction

    // one frame end: judge the drawn position, then move or go back
    task automatic model_frame(input game_pkg::btn_t b);
        bit hit;
        bit back;
        int gx;
        int gy;
        gx = GOAL_X - game_pkg::OBJ_SIZE;
        gy = GOAL_Y - game_pkg::OBJ_SIZE;
        hit = (mdl_x > gx) && (mdl_x < GOAL_X + game_pkg::OBJ_SIZE) &&
              (mdl_y > gy) && (mdl_y < GOAL_Y + game_pkg::OBJ_SIZE);
        back = hit || (mdl_time == 0);
        if (hit) begin
            mdl_level = (mdl_level + 1) % 16;
        end
        if (back) begin
            mdl_time = LEVEL_FRAMES;
            mdl_x = START_X;
            mdl_y = START_Y;
        end else begin
            mdl_time = mdl_time - 1;
            mdl_x = axis_move(mdl_x, b.left, b.right, H_ACTIVE - game_pkg::OBJ_SIZE);
            mdl_y = axis_move(mdl_y, b.up, b.down, V_ACTIVE - game_pkg::OBJ_SIZE);
        end
    endtask

    //////////////////////////////
    // checks and frame scanner
    //////////////////////////////

    task automatic check_value(input string what, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("ERROR %s: got %h expected %h", what, got, exp);
            err_count++;
        end
    endtask

    // position counts from the vs edge, where the pixel is (0, V_ACTIVE+V_FP)
    task automatic watch_cycle(output bit new_frame);
        game_pkg::rgb_t exp_rgb;
        @(negedge clk);
        new_frame = vs && !vs_prev;
        vs_prev = vs;
        if (new_frame) begin
            if (locked) begin
                check_value("vs high cycles", vs_len, V_SYNC * H_TOTAL);
            end
            locked = 1'b1;
            h = 0;
            v = V_ACTIVE + V_FP;
            vs_len = 0;
            hs_len = 0;
        end else if (locked) begin
            h = h + 1;
            if (h == H_TOTAL) begin
                h = 0;
                v = (v + 1) % V_TOTAL;
            end
        end
        if (locked) begin
            vs_len = vs_len + int'(vs);
            hs_len = hs_len + int'(hs);
            if (h == H_TOTAL - 1) begin
                check_value("hs high cycles", hs_len, H_SYNC);
                hs_len = 0;
            end
            if (scan_on) begin
                exp_rgb = expected_colour(h, v);
                check_count++;
                assert (rgb == exp_rgb) else begin
                    $display("ERROR rgb at (%0d,%0d): got %h expected %h", h, v, rgb, exp_rgb);
                    err_count++;
                end
            end
        end
    endtask

    task automatic run_frame(input game_pkg::btn_t b);
        bit new_frame;
        btn = b;
        new_frame = 1'b0;
        while (!new_frame) begin
            watch_cycle(new_frame);
        end
        model_frame(b);
        check_value("level", level, mdl_level);
        check_value("time_left", time_left, mdl_time);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int frames;
        int errs_before;
        void'($urandom(13));
        btn = '0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("hs", hs, 0);
        check_value("vs", vs, 0);
        // first frame end lines the scanner up with the raster
        run_frame('0);
        for (int i = 0; i < N_TESTS; i++) begin
            errs_before = err_count;
            frames = (t_frames[i] == 0) ? 1 + int'($urandom % 5) : t_frames[i];
            scan_on = t_scan[i];
            for (int f = 0; f < frames; f++) begin
                run_frame(t_btn[i]);
            end
            if (t_exp_x[i] >= 0) begin
                check_value("hero_x", mdl_x, t_exp_x[i]);
                check_value("hero_y", mdl_y, t_exp_y[i]);
                check_value("level", level, t_exp_lv[i]);
                check_value("time_left", time_left, t_exp_tl[i]);
            end
            $display("%s: %0d frames, %s", t_name[i], frames,
                     (err_count == errs_before) ? "ok" : "FAILED");
        end
        // one more frame draws where the last row left the hero
        scan_on = 1'b1;
        run_frame('0);
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // twice the longest table run, plus reset and the frames before and after the table
    initial begin : watchdog
        longint limit;
        int sum;
        sum = 2;
        for (int i = 0; i < N_TESTS; i++) begin
            sum = sum + ((t_frames[i] == 0) ? 5 : t_frames[i]);
        end
        limit = 2 * longint'(sum) * FRAME_CYCLES * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FP     = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BP     = 160,
    parameter int V_ACTIVE = 768,
    parameter int V_FP     = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BP     = 29
) (
    input  logic           clk,
    input  logic           rst_n,
    output game_pkg::vga_t vga,
    output logic           frame_start
);

    localparam game_pkg::coord_t H_LAST     = game_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
    localparam game_pkg::coord_t V_LAST     = game_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
    localparam game_pkg::coord_t H_SYNC_ON  = game_pkg::coord_t'(H_ACTIVE + H_FP);
    localparam game_pkg::coord_t H_SYNC_OFF = game_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam game_pkg::coord_t V_SYNC_ON  = game_pkg::coord_t'(V_ACTIVE + V_FP);
    localparam game_pkg::coord_t V_SYNC_OFF = game_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC);
    localparam game_pkg::coord_t H_VIS      = game_pkg::coord_t'(H_ACTIVE);
    localparam game_pkg::coord_t V_VIS      = game_pkg::coord_t'(V_ACTIVE);

    game_pkg::coord_t h_nxt;
    game_pkg::coord_t v_nxt;

    // counter advance, wrapping at the end of line and frame
    always_comb begin
        h_nxt = vga.hcount + 1'b1;
        v_nxt = vga.vcount;
        if (vga.hcount == H_LAST) begin
            h_nxt = '0;
            if (vga.vcount == V_LAST) begin
                v_nxt = '0;
            end else begin
                v_nxt = vga.vcount + 1'b1;
            end
        end
    end

    // decode from the next count so every output stays aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga         <= '0;
            frame_start <= 1'b0;
        end else begin
            vga.hcount  <= h_nxt;
            vga.vcount  <= v_nxt;
            vga.hsync   <= (h_nxt >= H_SYNC_ON) && (h_nxt < H_SYNC_OFF);
            vga.vsync   <= (v_nxt >= V_SYNC_ON) && (v_nxt < V_SYNC_OFF);
            vga.hblnk   <= (h_nxt >= H_VIS);
            vga.vblnk   <= (v_nxt >= V_VIS);
            // first line of vertical blanking
            frame_start <= (v_nxt == V_VIS) && (h_nxt == '0);
        end
    end

    hsync_in_blank: assert property (
        @(posedge clk) disable iff (!rst_n) vga.hsync |-> vga.hblnk
    ) else $error("hsync raised outside horizontal blanking");

    frame_start_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) frame_start |=> !frame_start
    ) else $error("frame_start held for more than one cycle");

endmodule
